/* hw/pid_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module pid_monitor (
	input wire logic clk,
	input wire logic rst_n,
	input wire tsp_pkg::ts_beat_t beat,
	input wire tsp_pkg::slot_cfg_t cfg,
	input wire logic arm,
	input wire logic [tsp_pkg::WORD_ADDR_BITS-1:0] rd_addr,
	output tsp_pkg::word_t matched_count,
	output logic capture_done,
	output tsp_pkg::word_t rd_word
);

	logic [3:0][7:0] cap_mem [tsp_pkg::PACK_WORDS];

	logic armed;
	logic in_pkt;
	logic hit;
	logic last_byte;
	logic wr_byte;

	assign hit = tsp_pkg::slot_match(beat, cfg);
	assign last_byte = (beat.index == 8'(tsp_pkg::PACK_BYTES - 1));

	// capture only from the start of a packet
	assign wr_byte = armed && beat.valid && (beat.sync || in_pkt)
		&& (beat.index < 8'(tsp_pkg::PACK_BYTES));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			matched_count <= '0;
		end else if (hit && beat.index == 8'(tsp_pkg::PID_READY_INDEX)) begin
			matched_count <= matched_count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			armed <= 1'b0;
			in_pkt <= 1'b0;
			capture_done <= 1'b0;
		end else if (arm) begin
			armed <= 1'b1;
			in_pkt <= 1'b0;
			capture_done <= 1'b0;
		end else if (wr_byte) begin
			in_pkt <= !last_byte;
			// matching packet complete, freeze the buffer
			if (last_byte && hit) begin
				armed <= 1'b0;
				capture_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_byte) begin
			cap_mem[beat.index[7:2]][beat.index[1:0]] <= beat.data;
		end
	end

	assign rd_word = cap_mem[rd_addr];

endmodule

`default_nettype wire

/* hw/pid_replacer.sv */
`timescale 1ns/1ps
`default_nettype none

module pid_replacer (
	input wire logic clk,
	input wire logic rst_n,
	input wire tsp_pkg::ts_beat_t beat_in,
	input wire tsp_pkg::slot_cfg_t cfg,
	input wire logic data_wr_en,
	input wire logic [tsp_pkg::WORD_ADDR_BITS-1:0] data_addr,
	input wire tsp_pkg::word_t data_wr_data,
	output tsp_pkg::ts_beat_t beat_out,
	output tsp_pkg::word_t matched_count,
	output tsp_pkg::word_t rd_word
);

	// replacement packet, byte k in word k/4 lane k%4
	logic [3:0][7:0] rep_mem [tsp_pkg::PACK_WORDS];

	logic hit;
	logic swap;
	logic [7:0] stored_byte;

	assign hit = tsp_pkg::slot_match(beat_in, cfg);

	// header bytes always pass through
	assign swap = hit
		&& (beat_in.index >= 8'(tsp_pkg::HEADER_BYTES))
		&& (beat_in.index < 8'(tsp_pkg::PACK_BYTES));

	assign stored_byte = rep_mem[beat_in.index[7:2]][beat_in.index[1:0]];

	always_ff @(posedge clk) begin
		if (data_wr_en) begin
			rep_mem[data_addr] <= data_wr_data;
		end
	end

	assign rd_word = rep_mem[data_addr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			beat_out <= '0;
		end else begin
			beat_out <= beat_in;
			if (swap) begin
				beat_out.data <= stored_byte;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			matched_count <= '0;
		end else if (hit && beat_in.index == 8'(tsp_pkg::PID_READY_INDEX)) begin
			matched_count <= matched_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/ts_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module ts_framer (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [7:0] mpeg_data,
	input wire logic mpeg_valid,
	input wire logic mpeg_sync,
	output tsp_pkg::ts_beat_t beat
);

	// position of the next byte, saturating on a missing sync
	logic [7:0] byte_cnt;
	logic [7:0] cur_index;
	logic [4:0] pid_hi;
	logic [tsp_pkg::PID_BITS-1:0] pid_q;

	assign cur_index = mpeg_sync ? 8'd0 : byte_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			byte_cnt <= '0;
			pid_hi <= '0;
			pid_q <= '0;
		end else if (mpeg_valid) begin
			if (cur_index != 8'hFF) begin
				byte_cnt <= cur_index + 8'd1;
			end else begin
				byte_cnt <= cur_index;
			end
			if (cur_index == 8'd1) begin
				pid_hi <= mpeg_data[4:0];
			end
			// low pid byte completes the pid
			if (cur_index == 8'd2) begin
				pid_q <= {pid_hi, mpeg_data};
			end
		end
	end

	// annotated beat, one cycle behind the input
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			beat <= '0;
		end else begin
			beat.valid <= mpeg_valid;
			beat.sync <= mpeg_valid && mpeg_sync;
			beat.data <= mpeg_data;
			beat.index <= cur_index;
			beat.pid <= pid_q;
			beat.pid_known <= mpeg_valid && (cur_index >= 8'(tsp_pkg::PID_READY_INDEX));
		end
	end

endmodule

`default_nettype wire

/* hw/tsp_pkg.sv */
`default_nettype none

package tsp_pkg;

	// sizes
	localparam int DATA_WIDTH = 32;
	localparam int ADDR_BITS = 10;
	localparam int PID_BITS = 13;
	localparam int PACK_BYTES = 188;
	localparam int PACK_WORDS = PACK_BYTES / (DATA_WIDTH / 8);
	localparam int WORD_ADDR_BITS = $clog2(PACK_WORDS);
	localparam int HEADER_BYTES = 4;
	// first byte position that carries a complete pid
	localparam int PID_READY_INDEX = 3;

	localparam int NUM_REPLACERS = 2;
	localparam int NUM_SLOTS = NUM_REPLACERS + 1;
	localparam int SLOT_BITS = $clog2(NUM_SLOTS);
	localparam int LATENCY = NUM_REPLACERS + 1;

	// register map
	localparam int ADDR_SLOT = 0;
	localparam int ADDR_PID = 2;
	localparam int ADDR_MATCH_ENABLE = 3;
	localparam int ADDR_CAPTURE = 4;
	localparam int ADDR_MATCHED_COUNT = 5;
	localparam int ADDR_DATA_BASE = 128;
	localparam logic [15:0] UNMAPPED_TAG = 16'hE000;

	typedef logic [DATA_WIDTH-1:0] word_t;

	// one stream byte with its packet position
	typedef struct packed {
		logic valid;
		logic sync;
		logic [7:0] data;
		logic [7:0] index;
		logic [PID_BITS-1:0] pid;
		logic pid_known;
	} ts_beat_t;

	typedef struct packed {
		logic enable;
		logic [PID_BITS-1:0] pid;
	} slot_cfg_t;

	// beat belongs to a packet this slot is filtering
	function automatic logic slot_match(ts_beat_t b, slot_cfg_t c);
		return b.valid && b.pid_known && c.enable && (b.pid == c.pid);
	endfunction

endpackage

`default_nettype wire

/* hw/tsp_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module tsp_ram (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic wen,
	input wire logic [tsp_pkg::ADDR_BITS-1:0] waddr,
	input wire tsp_pkg::word_t wdata,
	// full-word writes only, byte strobes unused
	input wire logic [tsp_pkg::DATA_WIDTH/8-1:0] wstrb,
	input wire logic ren,
	input wire logic [tsp_pkg::ADDR_BITS-1:0] raddr,
	output tsp_pkg::word_t rdata,
	input wire logic [7:0] mpeg_data,
	input wire logic mpeg_valid,
	input wire logic mpeg_sync,
	output logic [7:0] ts_out,
	output logic ts_out_valid,
	output logic ts_out_sync
);

	// chain[0] from the framer, chain[r+1] from replacer r
	tsp_pkg::ts_beat_t chain [tsp_pkg::NUM_REPLACERS+1];

	tsp_pkg::slot_cfg_t [tsp_pkg::NUM_SLOTS-1:0] cfg;
	logic arm;
	logic [tsp_pkg::NUM_REPLACERS-1:0] data_wr_en;
	logic [tsp_pkg::WORD_ADDR_BITS-1:0] data_addr;
	tsp_pkg::word_t data_wr_data;
	tsp_pkg::word_t monitor_count;
	tsp_pkg::word_t monitor_word;
	logic capture_done;
	tsp_pkg::word_t [tsp_pkg::NUM_REPLACERS-1:0] replacer_counts;
	tsp_pkg::word_t [tsp_pkg::NUM_REPLACERS-1:0] replacer_words;

	ts_framer u_framer (
		.clk(clk),
		.rst_n(rst_n),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.beat(chain[0])
	);

	// monitor taps the framer output
	pid_monitor u_monitor (
		.clk(clk),
		.rst_n(rst_n),
		.beat(chain[0]),
		.cfg(cfg[0]),
		.arm(arm),
		.rd_addr(data_addr),
		.matched_count(monitor_count),
		.capture_done(capture_done),
		.rd_word(monitor_word)
	);

	for (genvar r = 0; r < tsp_pkg::NUM_REPLACERS; r++) begin : g_replacer
		pid_replacer u_replacer (
			.clk(clk),
			.rst_n(rst_n),
			.beat_in(chain[r]),
			.cfg(cfg[r+1]),
			.data_wr_en(data_wr_en[r]),
			.data_addr(data_addr),
			.data_wr_data(data_wr_data),
			.beat_out(chain[r+1]),
			.matched_count(replacer_counts[r]),
			.rd_word(replacer_words[r])
		);
	end

	tsp_regs u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.wen(wen),
		.waddr(waddr),
		.wdata(wdata),
		.ren(ren),
		.raddr(raddr),
		.monitor_count(monitor_count),
		.capture_done(capture_done),
		.monitor_word(monitor_word),
		.replacer_counts(replacer_counts),
		.replacer_words(replacer_words),
		.rdata(rdata),
		.cfg(cfg),
		.arm(arm),
		.data_wr_en(data_wr_en),
		.data_addr(data_addr),
		.data_wr_data(data_wr_data)
	);

	assign ts_out = chain[tsp_pkg::NUM_REPLACERS].data;
	assign ts_out_valid = chain[tsp_pkg::NUM_REPLACERS].valid;
	assign ts_out_sync = chain[tsp_pkg::NUM_REPLACERS].sync;

endmodule

`default_nettype wire

/* hw/tsp_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module tsp_regs (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic wen,
	input wire logic [tsp_pkg::ADDR_BITS-1:0] waddr,
	input wire tsp_pkg::word_t wdata,
	input wire logic ren,
	input wire logic [tsp_pkg::ADDR_BITS-1:0] raddr,
	input wire tsp_pkg::word_t monitor_count,
	input wire logic capture_done,
	input wire tsp_pkg::word_t monitor_word,
	input wire tsp_pkg::word_t [tsp_pkg::NUM_REPLACERS-1:0] replacer_counts,
	input wire tsp_pkg::word_t [tsp_pkg::NUM_REPLACERS-1:0] replacer_words,
	output tsp_pkg::word_t rdata,
	output tsp_pkg::slot_cfg_t [tsp_pkg::NUM_SLOTS-1:0] cfg,
	output logic arm,
	output logic [tsp_pkg::NUM_REPLACERS-1:0] data_wr_en,
	output logic [tsp_pkg::WORD_ADDR_BITS-1:0] data_addr,
	output tsp_pkg::word_t data_wr_data
);

	logic [tsp_pkg::SLOT_BITS-1:0] slot;
	logic wr_window;
	logic rd_window;
	logic [tsp_pkg::WORD_ADDR_BITS-1:0] wr_off;
	logic [tsp_pkg::WORD_ADDR_BITS-1:0] rd_off;
	tsp_pkg::word_t sel_count;
	tsp_pkg::word_t sel_word;

	assign wr_window = wen && (waddr >= tsp_pkg::ADDR_DATA_BASE)
		&& (waddr < tsp_pkg::ADDR_DATA_BASE + tsp_pkg::PACK_WORDS);
	assign rd_window = (raddr >= tsp_pkg::ADDR_DATA_BASE)
		&& (raddr < tsp_pkg::ADDR_DATA_BASE + tsp_pkg::PACK_WORDS);
	assign wr_off = tsp_pkg::WORD_ADDR_BITS'(waddr - tsp_pkg::ADDR_DATA_BASE);
	assign rd_off = tsp_pkg::WORD_ADDR_BITS'(raddr - tsp_pkg::ADDR_DATA_BASE);

	// one word address shared by window writes and reads
	assign data_addr = wr_window ? wr_off : rd_off;
	assign data_wr_data = wdata;

	assign arm = wen && (waddr == tsp_pkg::ADDR_CAPTURE) && (slot == '0);

	always_comb begin
		data_wr_en = '0;
		for (int r = 0; r < tsp_pkg::NUM_REPLACERS; r++) begin
			data_wr_en[r] = wr_window && (slot == r + 1);
		end
	end

	// selected slot's count and buffer word
	always_comb begin
		sel_count = monitor_count;
		sel_word = monitor_word;
		for (int r = 0; r < tsp_pkg::NUM_REPLACERS; r++) begin
			if (slot == r + 1) begin
				sel_count = replacer_counts[r];
				sel_word = replacer_words[r];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot <= '0;
			cfg <= '0;
		end else if (wen) begin
			case (waddr)
				tsp_pkg::ADDR_SLOT: begin
					if (wdata < tsp_pkg::NUM_SLOTS) begin
						slot <= wdata[tsp_pkg::SLOT_BITS-1:0];
					end
				end
				tsp_pkg::ADDR_PID: begin
					cfg[slot].pid <= wdata[tsp_pkg::PID_BITS-1:0];
				end
				tsp_pkg::ADDR_MATCH_ENABLE: begin
					cfg[slot].enable <= (wdata == 1);
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ren) begin
			case (raddr)
				tsp_pkg::ADDR_SLOT: rdata <= tsp_pkg::word_t'(slot);
				tsp_pkg::ADDR_PID: rdata <= tsp_pkg::word_t'(cfg[slot].pid);
				tsp_pkg::ADDR_MATCH_ENABLE: rdata <= tsp_pkg::word_t'(cfg[slot].enable);
				tsp_pkg::ADDR_CAPTURE: rdata <= tsp_pkg::word_t'(capture_done);
				tsp_pkg::ADDR_MATCHED_COUNT: rdata <= sel_count;
				default: begin
					if (rd_window) begin
						rdata <= sel_word;
					end else begin
						rdata <= {tsp_pkg::UNMAPPED_TAG, 16'(raddr)};
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the tsp_ram testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tsp_ram.f --top-module tsp_ram_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtsp_ram_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
exit 0

/* tsp_ram.f */
+incdir+verif
hw/tsp_pkg.sv
hw/ts_framer.sv
hw/pid_monitor.sv
hw/pid_replacer.sv
hw/tsp_regs.sv
hw/tsp_ram.sv
verif/tsp_ram_tb.sv

/* verif/tsp_ram_tests.svh */
`ifndef TSP_RAM_TESTS_SVH
`define TSP_RAM_TESTS_SVH

localparam logic [12:0] PID_A = 13'h0123;
localparam logic [12:0] PID_B = 13'h1FE0;
localparam logic [12:0] PID_C = 13'h0A5A;

task automatic register_access();
	int unmapped [5] = '{1, 6, 127, 175, 1023};
	// reset state
	reg_expect(tsp_pkg::ADDR_SLOT, 0);
	reg_expect(tsp_pkg::ADDR_MATCH_ENABLE, 0);
	reg_expect(tsp_pkg::ADDR_MATCHED_COUNT, 0);
	reg_expect(tsp_pkg::ADDR_CAPTURE, 0);
	reg_write(tsp_pkg::ADDR_SLOT, 1);
	reg_expect(tsp_pkg::ADDR_SLOT, 1);
	reg_write(tsp_pkg::ADDR_PID, 32'hFFFF_FABC);
	reg_expect(tsp_pkg::ADDR_PID, 32'h1ABC);
	reg_write(tsp_pkg::ADDR_MATCH_ENABLE, 2);
	reg_expect(tsp_pkg::ADDR_MATCH_ENABLE, 0);
	reg_write(tsp_pkg::ADDR_MATCH_ENABLE, 1);
	reg_expect(tsp_pkg::ADDR_MATCH_ENABLE, 1);
	reg_write(tsp_pkg::ADDR_MATCH_ENABLE, 0);
	// out of range slot numbers leave the pointer alone
	reg_write(tsp_pkg::ADDR_SLOT, tsp_pkg::NUM_SLOTS);
	reg_expect(tsp_pkg::ADDR_SLOT, 1);
	reg_write(tsp_pkg::ADDR_SLOT, 32'h0001_0002);
	reg_expect(tsp_pkg::ADDR_SLOT, 1);
	reg_write(tsp_pkg::ADDR_SLOT, 2);
	reg_write(tsp_pkg::ADDR_PID, 32'h0055);
	reg_expect(tsp_pkg::ADDR_PID, 32'h0055);
	reg_write(tsp_pkg::ADDR_SLOT, 1);
	reg_expect(tsp_pkg::ADDR_PID, 32'h1ABC);
	foreach (unmapped[i]) begin
		reg_expect(unmapped[i], {tsp_pkg::UNMAPPED_TAG, 16'(unmapped[i])});
	end
endtask

task automatic pass_through();
	send_packet(PID_A, 1);
	send_packet(PID_B, 2);
	send_packet(PID_C, 3);
	wait_drain();
endtask

// fill a replacer's packet through the window and read it back
task automatic load_replacement(input int slot);
	reg_write(tsp_pkg::ADDR_SLOT, slot);
	for (int w = 0; w < tsp_pkg::PACK_WORDS; w++) begin
		reg_write(tsp_pkg::ADDR_DATA_BASE + w, {replacement_byte(slot, 4 * w + 3),
			replacement_byte(slot, 4 * w + 2), replacement_byte(slot, 4 * w + 1),
			replacement_byte(slot, 4 * w)});
	end
	for (int w = 0; w < tsp_pkg::PACK_WORDS; w++) begin
		reg_expect(tsp_pkg::ADDR_DATA_BASE + w, {replacement_byte(slot, 4 * w + 3),
			replacement_byte(slot, 4 * w + 2), replacement_byte(slot, 4 * w + 1),
			replacement_byte(slot, 4 * w)});
	end
endtask

task automatic replace_payload();
	load_replacement(1);
	set_filter(1, PID_A, 1'b1);
	send_packet(PID_A, 4);
	send_packet(PID_B, 5);
	send_packet(PID_A, 6);
	wait_drain();
endtask

task automatic stage_priority();
	load_replacement(2);
	set_filter(2, PID_A, 1'b1);
	send_packet(PID_A, 7);
	send_packet(PID_B, 8);
	wait_drain();
	set_filter(2, PID_A, 1'b0);
endtask

task automatic monitor_capture();
	set_filter(0, PID_C, 1'b1);
	reg_write(tsp_pkg::ADDR_CAPTURE, 1);
	reg_expect(tsp_pkg::ADDR_CAPTURE, 0);
	send_packet(PID_B, 9);
	send_packet(PID_C, 10);
	send_packet(PID_B, 11);
	wait_drain();
	reg_expect(tsp_pkg::ADDR_CAPTURE, 1);
	// window now shows the captured C packet
	for (int w = 0; w < tsp_pkg::PACK_WORDS; w++) begin
		reg_expect(tsp_pkg::ADDR_DATA_BASE + w, {packet_byte(PID_C, 10, 4 * w + 3),
			packet_byte(PID_C, 10, 4 * w + 2), packet_byte(PID_C, 10, 4 * w + 1),
			packet_byte(PID_C, 10, 4 * w)});
	end
	for (int s = 0; s < tsp_pkg::NUM_SLOTS; s++) begin
		reg_write(tsp_pkg::ADDR_SLOT, s);
		reg_expect(tsp_pkg::ADDR_MATCHED_COUNT, exp_count[s]);
	end
	// a fresh arm clears the done flag
	reg_write(tsp_pkg::ADDR_SLOT, 0);
	reg_write(tsp_pkg::ADDR_CAPTURE, 1);
	reg_expect(tsp_pkg::ADDR_CAPTURE, 0);
endtask

`endif

/* verif/tsp_ram_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tsp_ram_tb;

	localparam int CLK_PERIOD = 100;
	localparam logic [31:0] RAND_SEED = 32'h2e5e_1d92;
	// packets sent over all tests
	localparam int NUM_PACKETS = 11;
	localparam int WATCHDOG_CYCLES = NUM_PACKETS * tsp_pkg::PACK_BYTES * 3 + 3000;

	typedef struct packed {
		logic [7:0] data;
		logic sync;
		logic [31:0] due;
	} exp_beat_t;

	logic clk;
	logic rst_n;
	logic wen;
	logic [tsp_pkg::ADDR_BITS-1:0] waddr;
	tsp_pkg::word_t wdata;
	logic [3:0] wstrb;
	logic ren;
	logic [tsp_pkg::ADDR_BITS-1:0] raddr;
	tsp_pkg::word_t rdata;
	logic [7:0] mpeg_data;
	logic mpeg_valid;
	logic mpeg_sync;
	logic [7:0] ts_out;
	logic ts_out_valid;
	logic ts_out_sync;

	// reference copy of the slot setup
	logic model_en [tsp_pkg::NUM_SLOTS];
	logic [12:0] model_pid [tsp_pkg::NUM_SLOTS];
	int exp_count [tsp_pkg::NUM_SLOTS];

	exp_beat_t exp_q [$];
	exp_beat_t sb_beat;
	logic [31:0] neg_cycle;

	tsp_ram u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.wen(wen),
		.waddr(waddr),
		.wdata(wdata),
		.wstrb(wstrb),
		.ren(ren),
		.raddr(raddr),
		.rdata(rdata),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.ts_out(ts_out),
		.ts_out_valid(ts_out_valid),
		.ts_out_sync(ts_out_sync)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		assert (got === want) else begin
			report_failure($sformatf("Error at %0d ns: %s is 0x%0h, expected 0x%0h",
				$time, name, got, want));
		end
	endtask

	task automatic reg_write(input int addr, input logic [31:0] data);
		@(posedge clk);
		wen <= 1'b1;
		waddr <= tsp_pkg::ADDR_BITS'(addr);
		wdata <= data;
		wstrb <= 4'hF;
		@(posedge clk);
		wen <= 1'b0;
	endtask

	// rdata is valid one cycle after ren is sampled
	task automatic reg_read(input int addr, output logic [31:0] data);
		@(posedge clk);
		ren <= 1'b1;
		raddr <= tsp_pkg::ADDR_BITS'(addr);
		@(posedge clk);
		ren <= 1'b0;
		@(negedge clk);
		data = rdata;
	endtask

	task automatic reg_expect(input int addr, input logic [31:0] want);
		logic [31:0] got;
		reg_read(addr, got);
		check_value($sformatf("rdata[0x%0h]", addr), got, want);
	endtask

	task automatic set_filter(input int slot, input logic [12:0] pid, input logic en);
		reg_write(tsp_pkg::ADDR_SLOT, slot);
		reg_write(tsp_pkg::ADDR_PID, {19'd0, pid});
		reg_write(tsp_pkg::ADDR_MATCH_ENABLE, {31'd0, en});
		model_pid[slot] = pid;
		model_en[slot] = en;
	endtask

	// sync byte, pid split over bytes 1 and 2, payload from the seed
	function automatic logic [7:0] packet_byte(input logic [12:0] pid, input int seed,
		input int k);
		if (k == 0) return 8'h47;
		if (k == 1) return {3'b010, pid[12:8]};
		if (k == 2) return pid[7:0];
		if (k == 3) return 8'h10 | 8'(seed & 15);
		return 8'(seed * 31 + k * 7 + (k >> 3));
	endfunction

	function automatic logic [7:0] replacement_byte(input int slot, input int k);
		return 8'(slot * 8'h55 + k * 5 + 8'h3C);
	endfunction

	// later stage wins when both replacers match
	function automatic logic [7:0] expected_byte(input logic [12:0] pid, input int seed,
		input int k);
		logic [7:0] b;
		b = packet_byte(pid, seed, k);
		for (int s = 1; s < tsp_pkg::NUM_SLOTS; s++) begin
			if (k >= tsp_pkg::HEADER_BYTES && model_en[s] && model_pid[s] == pid) begin
				b = replacement_byte(s, k);
			end
		end
		return b;
	endfunction

	task automatic idle_cycle();
		@(posedge clk);
		mpeg_valid <= 1'b0;
		mpeg_sync <= 1'b0;
		mpeg_data <= 8'($urandom);
	endtask

	task automatic drive_byte(input logic [7:0] data, input logic is_sync,
		input logic [7:0] exp_data);
		@(posedge clk);
		mpeg_data <= data;
		mpeg_valid <= 1'b1;
		mpeg_sync <= is_sync;
		// due at the negedge LATENCY cycles after the one that sees the byte
		exp_q.push_back('{data: exp_data, sync: is_sync,
			due: neg_cycle + 32'd1 + 32'(tsp_pkg::LATENCY)});
	endtask

	task automatic send_packet(input logic [12:0] pid, input int seed);
		int gap;
		for (int s = 0; s < tsp_pkg::NUM_SLOTS; s++) begin
			if (model_en[s] && model_pid[s] == pid) exp_count[s]++;
		end
		for (int k = 0; k < tsp_pkg::PACK_BYTES; k++) begin
			drive_byte(packet_byte(pid, seed, k), k == 0, expected_byte(pid, seed, k));
			gap = int'($urandom % 3);
			repeat (gap) idle_cycle();
		end
		idle_cycle();
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) @(negedge clk);
	endtask

	// output scoreboard
	always @(negedge clk) begin
		neg_cycle = neg_cycle + 32'd1;
		if (ts_out_valid === 1'b1) begin
			assert (exp_q.size() != 0) else report_failure("output byte with none in flight");
			if (exp_q.size() != 0) begin
				sb_beat = exp_q.pop_front();
				check_value("ts_out", 32'(ts_out), 32'(sb_beat.data));
				check_value("ts_out_sync", 32'(ts_out_sync), 32'(sb_beat.sync));
				check_value("ts_out_valid cycle", neg_cycle, sb_beat.due);
			end
		end else if (exp_q.size() != 0) begin
			assert (exp_q[0].due != neg_cycle) else begin
				report_failure("ts_out_valid stayed low when an output byte was due");
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles before the tests ended", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$fatal(1, "timeout");
	end

	`include "tsp_ram_tests.svh"

	initial begin
		void'($urandom(RAND_SEED));
		neg_cycle = '0;
		rst_n = 1'b0;
		wen = 1'b0;
		waddr = '0;
		wdata = '0;
		wstrb = '0;
		ren = 1'b0;
		raddr = '0;
		mpeg_data = '0;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		for (int s = 0; s < tsp_pkg::NUM_SLOTS; s++) begin
			model_en[s] = 1'b0;
			model_pid[s] = '0;
			exp_count[s] = 0;
		end
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		register_access();
		pass_through();
		replace_payload();
		stage_priority();
		monitor_capture();
		if (exp_q.size() != 0) begin
			$display("%0d output bytes never appeared", exp_q.size());
			$display("TESTBENCH FAILED");
			$fatal(1, "missing output");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
